//--- exu_pkg.sv
`default_nettype none

package exu_pkg;

  parameter int XLEN = 64;

  // Operation class handed over by the decoder
  typedef enum logic [2:0] {
    OP_ALU    = 3'd0,
    OP_LOAD   = 3'd1,
    OP_STORE  = 3'd2,
    OP_BRANCH = 3'd3,
    OP_JUMP   = 3'd4,
    OP_SYSTEM = 3'd5
  } op_class_e;

  // ALU function, branches reuse it as the compare test
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,            // Branch taken on zero
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,            // Branch taken on nonzero
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,            // Branch taken on 1
    ALU_SLTU = 4'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    SYS_CSRRW  = 3'd0,
    SYS_CSRRS  = 3'd1,
    SYS_CSRRC  = 3'd2,
    SYS_ECALL  = 3'd3,
    SYS_EBREAK = 3'd4,
    SYS_MRET   = 3'd5
  } sys_op_e;

  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_MEM_WAIT = 2'd1,         // Load or store outstanding
    ST_HOLD     = 2'd2          // Result waits for retire
  } exu_state_e;

  // Machine-mode CSR addresses
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  // Environment call from M-mode
  localparam int MCAUSE_ECALL_M = 11;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

endpackage

`default_nettype wire

//--- exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  alu_op_e         alu_op_i,
  output logic [XLEN-1:0] result_o
);

  logic [5:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = src2_i[5:0];
  assign lt_signed   = $signed(src1_i) < $signed(src2_i);
  assign lt_unsigned = src1_i < src2_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = src1_i + src2_i;
      ALU_SUB:  result_o = src1_i - src2_i;
      ALU_AND:  result_o = src1_i & src2_i;
      ALU_OR:   result_o = src1_i | src2_i;
      ALU_XOR:  result_o = src1_i ^ src2_i;
      ALU_SLL:  result_o = src1_i << shamt;
      ALU_SRL:  result_o = src1_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(src1_i) >>> shamt);
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- exu_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module exu_csr_file import exu_pkg::*; #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            csr_we_i,
  input  logic [11:0]     csr_addr_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  logic            ecall_en_i,
  input  logic [XLEN-1:0] ecall_pc_i,
  output logic [XLEN-1:0] csr_rdata_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] mepc_o
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS: csr_rdata_o = mstatus;
      CSR_MTVEC:   csr_rdata_o = mtvec;
      CSR_MEPC:    csr_rdata_o = mepc;
      CSR_MCAUSE:  csr_rdata_o = mcause;
      default:     csr_rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (csr_we_i) begin
        case (csr_addr_i)
          CSR_MSTATUS: mstatus <= csr_wdata_i;
          CSR_MTVEC:   mtvec   <= csr_wdata_i;
          CSR_MEPC:    mepc    <= csr_wdata_i;
          CSR_MCAUSE:  mcause  <= csr_wdata_i;
          default: ;                            // Unknown address, write dropped
        endcase
      end
      if (ecall_en_i) begin                     // Second port, trap entry
        mepc   <= ecall_pc_i;
        mcause <= XLEN'(MCAUSE_ECALL_M);
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

`default_nettype wire

//--- exu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exu_stage import exu_pkg::*; #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  input  op_class_e       op_class_i,
  input  alu_op_e         alu_op_i,
  input  sys_op_e         sys_op_i,
  input  logic [4:0]      rd_i,
  input  logic            rwen_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [XLEN-1:0] base_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [11:0]     csr_addr_i,
  output logic            in_ready_o,
  input  logic [XLEN-1:0] alu_result_i,
  output alu_op_e         alu_op_o,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i,
  output logic            csr_we_o,
  output logic [11:0]     csr_addr_o,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic            ecall_en_o,
  output logic [XLEN-1:0] ecall_pc_o,
  input  logic            mem_resp_i,
  input  logic [XLEN-1:0] mem_rdata_i,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [XLEN-1:0] mem_wdata_o,
  input  logic            ex_ready_i,
  output logic            ex_valid_o,
  output logic [4:0]      ex_rd_o,
  output logic            ex_rwen_o,
  output logic [XLEN-1:0] ex_wdata_o,
  output logic [XLEN-1:0] ex_pc_o,
  output logic            ex_redirect_o,
  output logic [XLEN-1:0] ex_target_o,
  output logic            ex_ebreak_o
);

  exu_state_e      state;
  op_class_e       op_class_q;
  alu_op_e         alu_op_q;
  sys_op_e         sys_op_q;
  logic [4:0]      rd_q;
  logic            rwen_q;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] addr_q;
  logic [XLEN-1:0] result_q;
  logic [XLEN-1:0] load_data_q;
  logic [11:0]     csr_addr_q;
  logic            accept;
  logic            handoff;
  logic            is_sys;
  logic            br_taken;
  logic            csr_wr_op;
  logic [XLEN-1:0] mret_status;

  assign in_ready_o = (state == ST_IDLE);
  assign accept     = in_valid_i && in_ready_o;
  assign ex_valid_o = (state == ST_HOLD);
  assign handoff    = ex_valid_o && ex_ready_i;
  assign is_sys     = (op_class_q == OP_SYSTEM);
  assign alu_op_o   = alu_op_i;                 // ALU sees the issue operands

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (in_valid_i) begin
            if (op_class_i == OP_LOAD || op_class_i == OP_STORE) begin
              state <= ST_MEM_WAIT;
            end else begin
              state <= ST_HOLD;
            end
          end
        end
        ST_MEM_WAIT: if (mem_resp_i) state <= ST_HOLD;
        ST_HOLD:     if (ex_ready_i) state <= ST_IDLE;
        default:     state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_class_q <= op_class_i;
      alu_op_q   <= alu_op_i;
      sys_op_q   <= sys_op_i;
      rd_q       <= rd_i;
      rwen_q     <= rwen_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      pc_q       <= pc_i;
      addr_q     <= base_i + imm_i;             // Memory address or jump target
      result_q   <= alu_result_i;
      csr_addr_q <= csr_addr_i;
    end
    if (state == ST_MEM_WAIT && mem_resp_i) begin
      load_data_q <= mem_rdata_i;
    end
  end

  assign mem_req_o   = (state == ST_MEM_WAIT);
  assign mem_we_o    = (op_class_q == OP_STORE);
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = src2_q;

  always_comb begin
    case (alu_op_q)
      ALU_SUB:           br_taken = (result_q == '0);
      ALU_XOR:           br_taken = (result_q != '0);
      ALU_SLT, ALU_SLTU: br_taken = (result_q == XLEN'(1));
      default:           br_taken = 1'b0;
    endcase
  end

  always_comb begin
    mret_status                   = csr_rdata_i;
    mret_status[MSTATUS_MIE_BIT]  = csr_rdata_i[MSTATUS_MPIE_BIT];
    mret_status[MSTATUS_MPIE_BIT] = 1'b1;
  end

  always_comb begin
    csr_addr_o  = csr_addr_q;
    csr_wdata_o = '0;
    csr_wr_op   = 1'b1;
    case (sys_op_q)
      SYS_CSRRW: csr_wdata_o = src1_q;
      SYS_CSRRS: csr_wdata_o = csr_rdata_i | src1_q;
      SYS_CSRRC: csr_wdata_o = csr_rdata_i & ~src1_q;
      SYS_ECALL: begin
        csr_addr_o  = CSR_MCAUSE;
        csr_wdata_o = XLEN'(MCAUSE_ECALL_M);
      end
      SYS_MRET: begin
        csr_addr_o  = CSR_MSTATUS;
        csr_wdata_o = mret_status;
      end
      default: csr_wr_op = 1'b0;                // EBREAK leaves the CSRs alone
    endcase
  end

  assign csr_we_o   = handoff && is_sys && csr_wr_op;
  assign ecall_en_o = handoff && is_sys && (sys_op_q == SYS_ECALL);
  assign ecall_pc_o = pc_q;

  always_comb begin
    ex_redirect_o = 1'b0;
    ex_ebreak_o   = 1'b0;
    ex_target_o   = addr_q;
    case (op_class_q)
      OP_JUMP:   ex_redirect_o = 1'b1;
      OP_BRANCH: ex_redirect_o = br_taken;
      OP_SYSTEM: begin
        case (sys_op_q)
          SYS_ECALL: begin
            ex_redirect_o = 1'b1;
            ex_target_o   = mtvec_i;
          end
          SYS_MRET: begin
            ex_redirect_o = 1'b1;
            ex_target_o   = mepc_i;
          end
          SYS_EBREAK: begin
            ex_redirect_o = 1'b1;
            ex_ebreak_o   = 1'b1;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign ex_rd_o    = rd_q;
  assign ex_rwen_o  = rwen_q;
  assign ex_pc_o    = pc_q;
  assign ex_wdata_o = (op_class_q == OP_LOAD) ? load_data_q :
                      is_sys                  ? csr_rdata_i : result_q;

endmodule

`default_nettype wire

//--- exu_data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module exu_data_mem import exu_pkg::*; #(
  parameter int XLEN      = exu_pkg::XLEN,
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            mem_req_i,
  input  logic            mem_we_i,
  input  logic [XLEN-1:0] mem_addr_i,
  input  logic [XLEN-1:0] mem_wdata_i,
  output logic            mem_resp_o,
  output logic [XLEN-1:0] mem_rdata_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [7:0]      lfsr;
  logic            busy;
  logic [1:0]      count;
  logic [AW-1:0]   idx;

  assign idx = AW'((mem_addr_i >> 3) % MEM_WORDS);   // 64-bit words

  // x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= 8'h5a;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      count <= 2'd0;
    end else if (!busy) begin
      if (mem_req_i) begin
        busy  <= 1'b1;
        count <= lfsr[1:0];                     // 1 to 4 cycle delay
      end
    end else if (count == 2'd0) begin
      busy <= 1'b0;
    end else begin
      count <= count - 2'd1;
    end
  end

  assign mem_resp_o  = busy && (count == 2'd0);
  assign mem_rdata_o = mem[idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_resp_o && mem_we_i) begin
      mem[idx] <= mem_wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- exu_retire.sv
`timescale 1ns/1ps
`default_nettype none

module exu_retire import exu_pkg::*; #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            ex_valid_i,
  input  logic [4:0]      ex_rd_i,
  input  logic            ex_rwen_i,
  input  logic [XLEN-1:0] ex_wdata_i,
  input  logic [XLEN-1:0] ex_pc_i,
  input  logic            ex_redirect_i,
  input  logic [XLEN-1:0] ex_target_i,
  input  logic            ex_ebreak_i,
  input  logic            retire_ready_i,
  output logic            ex_ready_o,
  output logic            retire_valid_o,
  output logic [4:0]      retire_rd_o,
  output logic            retire_rwen_o,
  output logic [XLEN-1:0] retire_wdata_o,
  output logic [XLEN-1:0] retire_npc_o,
  output logic            retire_ebreak_o
);

  logic valid_q;
  logic load;

  assign ex_ready_o     = !valid_q || retire_ready_i;   // Empty or draining
  assign load           = ex_valid_i && ex_ready_o;
  assign retire_valid_o = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (retire_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      retire_rd_o     <= ex_rd_i;
      retire_rwen_o   <= ex_rwen_i && (ex_rd_i != 5'd0);   // x0 is never written
      retire_wdata_o  <= ex_wdata_i;
      retire_npc_o    <= ex_redirect_i ? ex_target_i : ex_pc_i + XLEN'(4);
      retire_ebreak_o <= ex_ebreak_i;
    end
  end

endmodule

`default_nettype wire

//--- exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; #(
  parameter int XLEN      = exu_pkg::XLEN,
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid_i,
  input  op_class_e       op_class_i,
  input  alu_op_e         alu_op_i,
  input  sys_op_e         sys_op_i,
  input  logic [4:0]      rd_i,
  input  logic            rwen_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [XLEN-1:0] base_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [11:0]     csr_addr_i,
  output logic            in_ready_o,
  input  logic            retire_ready_i,
  output logic            retire_valid_o,
  output logic [4:0]      retire_rd_o,
  output logic            retire_rwen_o,
  output logic [XLEN-1:0] retire_wdata_o,
  output logic [XLEN-1:0] retire_npc_o,
  output logic            retire_ebreak_o
);

  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_result;
  logic            csr_we;
  logic [11:0]     csr_addr;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] csr_rdata;
  logic            ecall_en;
  logic [XLEN-1:0] ecall_pc;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic            mem_req;
  logic            mem_we;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_resp;
  logic [XLEN-1:0] mem_rdata;
  logic            ex_valid;
  logic            ex_ready;
  logic [4:0]      ex_rd;
  logic            ex_rwen;
  logic [XLEN-1:0] ex_wdata;
  logic [XLEN-1:0] ex_pc;
  logic            ex_redirect;
  logic [XLEN-1:0] ex_target;
  logic            ex_ebreak;

  exu_stage #(.XLEN(XLEN)) u_stage (
    .clk, .rst, .in_valid_i, .op_class_i, .alu_op_i, .sys_op_i, .rd_i, .rwen_i,
    .src1_i, .src2_i, .base_i, .imm_i, .pc_i, .csr_addr_i, .in_ready_o,
    .alu_result_i(alu_result), .alu_op_o(alu_op),
    .csr_rdata_i(csr_rdata), .mtvec_i(mtvec), .mepc_i(mepc),
    .csr_we_o(csr_we), .csr_addr_o(csr_addr), .csr_wdata_o(csr_wdata),
    .ecall_en_o(ecall_en), .ecall_pc_o(ecall_pc),
    .mem_resp_i(mem_resp), .mem_rdata_i(mem_rdata),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .ex_ready_i(ex_ready), .ex_valid_o(ex_valid), .ex_rd_o(ex_rd), .ex_rwen_o(ex_rwen),
    .ex_wdata_o(ex_wdata), .ex_pc_o(ex_pc), .ex_redirect_o(ex_redirect),
    .ex_target_o(ex_target), .ex_ebreak_o(ex_ebreak)
  );

  exu_alu #(.XLEN(XLEN)) u_alu (
    .src1_i, .src2_i, .alu_op_i(alu_op), .result_o(alu_result)
  );

  exu_csr_file #(.XLEN(XLEN)) u_csr (
    .clk, .rst, .csr_we_i(csr_we), .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata),
    .ecall_en_i(ecall_en), .ecall_pc_i(ecall_pc),
    .csr_rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  exu_data_mem #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) u_mem (
    .clk, .rst, .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
    .mem_wdata_i(mem_wdata), .mem_resp_o(mem_resp), .mem_rdata_o(mem_rdata)
  );

  exu_retire #(.XLEN(XLEN)) u_retire (
    .clk, .rst, .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_rwen_i(ex_rwen),
    .ex_wdata_i(ex_wdata), .ex_pc_i(ex_pc), .ex_redirect_i(ex_redirect),
    .ex_target_i(ex_target), .ex_ebreak_i(ex_ebreak), .retire_ready_i,
    .ex_ready_o(ex_ready), .retire_valid_o, .retire_rd_o, .retire_rwen_o,
    .retire_wdata_o, .retire_npc_o, .retire_ebreak_o
  );

endmodule

`default_nettype wire

//--- exu_props.sv
`timescale 1ns/1ps
`default_nettype none

module exu_props #(
  parameter int PW = 1
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          valid_i,
  input  logic          ready_i,
  input  logic [PW-1:0] payload_i,
  input  logic          req_i,
  input  logic          resp_i,
  input  logic          in_ready_i
);

  // Producer holds valid and payload until the consumer takes them
  a_hold_payload: assert property (
    @(posedge clk) disable iff (rst)
      valid_i && !ready_i |=> valid_i && $stable(payload_i)
  ) else $error("valid dropped or payload changed without ready");

  a_mem_req_held: assert property (
    @(posedge clk) disable iff (rst)
      req_i && !resp_i |=> req_i
  ) else $error("mem_req dropped before mem_resp");

  // Once busy, no new issue until the result is handed off
  a_no_issue_while_valid: assert property (
    @(posedge clk) disable iff (rst)
      !in_ready_i && !(valid_i && ready_i) |=> !in_ready_i
  ) else $error("in_ready rose before the pending result was handed off");

endmodule

`default_nettype wire

//--- tb_exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top import exu_pkg::*; ();

  localparam int MEM_WORDS  = 256;
  localparam int NUM_OPS    = 600;
  localparam int CLK_PERIOD = 20;
  localparam int TIMEOUT_NS = (NUM_OPS * 12 + 16) * CLK_PERIOD;

  typedef struct packed {
    logic [31:0]     id;
    op_class_e       op;
    logic [4:0]      rd;
    logic            rwen;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] npc;
    logic            ebreak;
  } retire_rec_t;

  logic            clk;
  logic            rst;
  logic            in_valid_i;
  op_class_e       op_class_i;
  alu_op_e         alu_op_i;
  sys_op_e         sys_op_i;
  logic [4:0]      rd_i;
  logic            rwen_i;
  logic [XLEN-1:0] src1_i;
  logic [XLEN-1:0] src2_i;
  logic [XLEN-1:0] base_i;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] pc_i;
  logic [11:0]     csr_addr_i;
  logic            in_ready_o;
  logic            retire_ready_i;
  logic            retire_valid_o;
  logic [4:0]      retire_rd_o;
  logic            retire_rwen_o;
  logic [XLEN-1:0] retire_wdata_o;
  logic [XLEN-1:0] retire_npc_o;
  logic            retire_ebreak_o;

  retire_rec_t     expected_q[$];
  logic [XLEN-1:0] mem_model [MEM_WORDS];
  logic [XLEN-1:0] mstatus_m;
  logic [XLEN-1:0] mtvec_m;
  logic [XLEN-1:0] mepc_m;
  logic [XLEN-1:0] mcause_m;
  integer          seed = 32'h2fd3;
  integer          ready_seed = ~32'h2fd3;    // Own stream for retire back-pressure
  int              data_errors = 0;
  int              rd_errors = 0;
  int              flag_errors = 0;
  int              other_errors = 0;
  int              issued = 0;
  int              retired = 0;

  exu_top #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) UUT (
    .clk, .rst, .in_valid_i, .op_class_i, .alu_op_i, .sys_op_i, .rd_i, .rwen_i,
    .src1_i, .src2_i, .base_i, .imm_i, .pc_i, .csr_addr_i, .in_ready_o,
    .retire_ready_i, .retire_valid_o, .retire_rd_o, .retire_rwen_o,
    .retire_wdata_o, .retire_npc_o, .retire_ebreak_o
  );

  bind exu_stage exu_props #(.PW(3 * exu_pkg::XLEN + 8)) u_stage_props (
    .clk(clk), .rst(rst), .valid_i(ex_valid_o), .ready_i(ex_ready_i),
    .payload_i({ex_rd_o, ex_rwen_o, ex_wdata_o, ex_pc_o, ex_redirect_o, ex_target_o,
                ex_ebreak_o}),
    .req_i(mem_req_o), .resp_i(mem_resp_i), .in_ready_i(in_ready_o)
  );

  bind exu_retire exu_props #(.PW(2 * exu_pkg::XLEN + 7)) u_retire_props (
    .clk(clk), .rst(rst), .valid_i(retire_valid_o), .ready_i(retire_ready_i),
    .payload_i({retire_rd_o, retire_rwen_o, retire_wdata_o, retire_npc_o, retire_ebreak_o}),
    .req_i(1'b0), .resp_i(1'b0), .in_ready_i(1'b0)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [XLEN-1:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [XLEN-1:0] expected_alu(alu_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
    logic [5:0] sh;
    sh = b[5:0];
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return XLEN'($signed(a) >>> sh);
      ALU_SLT:  return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
      ALU_SLTU: return (a < b) ? XLEN'(1) : '0;
      default:  return '0;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] csr_read(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return mstatus_m;
      CSR_MTVEC:   return mtvec_m;
      CSR_MEPC:    return mepc_m;
      CSR_MCAUSE:  return mcause_m;
      default:     return '0;
    endcase
  endfunction

  task automatic csr_write(input logic [11:0] addr, input logic [XLEN-1:0] value);
    case (addr)
      CSR_MSTATUS: mstatus_m = value;
      CSR_MTVEC:   mtvec_m   = value;
      CSR_MEPC:    mepc_m    = value;
      CSR_MCAUSE:  mcause_m  = value;
      default: ;
    endcase
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      data_errors++;
    end
  endtask

  task automatic check_rd(input string name, input logic [4:0] expected,
                          input logic [4:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      rd_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
      flag_errors++;
    end
  endtask

  // Drives one random operation and queues what retire must show for it
  task automatic make_op(input int n);
    int              widx;
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] old;
    logic [XLEN-1:0] addr;
    logic            taken;
    retire_rec_t     rec;
    op_class_i = op_class_e'($unsigned($random(seed)) % 6);
    alu_op_i   = alu_op_e'($unsigned($random(seed)) % 10);
    sys_op_i   = sys_op_e'($unsigned($random(seed)) % 6);
    rd_i       = 5'($random(seed));
    rwen_i     = 1'($random(seed));
    src1_i     = random_word();
    src2_i     = random_word();
    base_i     = random_word();
    imm_i      = random_word();
    pc_i       = random_word() & ~XLEN'(3);
    csr_addr_i = 12'h7c0;                     // Unimplemented CSR
    case (op_class_i)
      OP_BRANCH: begin
        case ($unsigned($random(seed)) % 4)
          0:       alu_op_i = ALU_SUB;
          1:       alu_op_i = ALU_XOR;
          2:       alu_op_i = ALU_SLT;
          default: alu_op_i = ALU_SLTU;
        endcase
        if ($random(seed) & 1) src2_i = src1_i;
      end
      OP_JUMP: begin
        alu_op_i = ALU_ADD;                   // Link address
        src1_i   = pc_i;
        src2_i   = XLEN'(4);
      end
      OP_SYSTEM: begin
        case ($unsigned($random(seed)) % 5)
          0:       csr_addr_i = CSR_MSTATUS;
          1:       csr_addr_i = CSR_MTVEC;
          2:       csr_addr_i = CSR_MEPC;
          3:       csr_addr_i = CSR_MCAUSE;
          default: csr_addr_i = 12'h7c0;
        endcase
      end
      default: ;
    endcase
    res        = expected_alu(alu_op_i, src1_i, src2_i);
    rec.id     = 32'(n);
    rec.op     = op_class_i;
    rec.rd     = rd_i;
    rec.rwen   = rwen_i && (rd_i != 5'd0);
    rec.wdata  = res;
    rec.npc    = pc_i + XLEN'(4);
    rec.ebreak = 1'b0;
    case (op_class_i)
      OP_LOAD, OP_STORE: begin
        if ($random(seed) & 1) widx = int'($unsigned($random(seed)) % 16);  // Reuse words
        else widx = int'($unsigned($random(seed)) % MEM_WORDS);
        addr  = (XLEN'(widx) << 3) | XLEN'($unsigned($random(seed)) % 8);
        imm_i = addr - base_i;
        if (op_class_i == OP_STORE) mem_model[widx] = src2_i;
        else rec.wdata = mem_model[widx];
      end
      OP_BRANCH: begin
        case (alu_op_i)
          ALU_SUB: taken = (res == '0);
          ALU_XOR: taken = (res != '0);
          default: taken = (res == XLEN'(1));
        endcase
        if (taken) rec.npc = base_i + imm_i;
      end
      OP_JUMP: rec.npc = base_i + imm_i;
      OP_SYSTEM: begin
        old = csr_read(csr_addr_i);
        case (sys_op_i)
          SYS_CSRRW: csr_write(csr_addr_i, src1_i);
          SYS_CSRRS: csr_write(csr_addr_i, old | src1_i);
          SYS_CSRRC: csr_write(csr_addr_i, old & ~src1_i);
          SYS_ECALL: begin
            old      = mcause_m;
            rec.npc  = mtvec_m;
            mepc_m   = pc_i;
            mcause_m = XLEN'(MCAUSE_ECALL_M);
          end
          SYS_MRET: begin
            old     = mstatus_m;
            rec.npc = mepc_m;
            mstatus_m[MSTATUS_MIE_BIT]  = mstatus_m[MSTATUS_MPIE_BIT];
            mstatus_m[MSTATUS_MPIE_BIT] = 1'b1;
          end
          default: begin                      // EBREAK
            rec.npc    = base_i + imm_i;
            rec.ebreak = 1'b1;
          end
        endcase
        rec.wdata = old;
      end
      default: ;
    endcase
    expected_q.push_back(rec);
    issued++;
  endtask

  task automatic compare_retire();
    retire_rec_t rec;
    op_class_e   op;
    string       tag;
    if (expected_q.size() == 0) begin
      $display("Retire seen with no operation outstanding");
      other_errors++;
    end else begin
      rec = expected_q.pop_front();
      op  = rec.op;
      tag = $sformatf("op %0d %s", rec.id, op.name());
      check_rd({tag, " rd"}, rec.rd, retire_rd_o);
      check_flag({tag, " rwen"}, rec.rwen, retire_rwen_o);
      check_data({tag, " wdata"}, rec.wdata, retire_wdata_o);
      check_data({tag, " npc"}, rec.npc, retire_npc_o);
      check_flag({tag, " ebreak"}, rec.ebreak, retire_ebreak_o);
    end
    retired++;
  endtask

  // Handshake completes at the next rising edge
  always @(negedge clk) begin
    retire_ready_i = (($random(ready_seed) & 3) != 0);
    if (!rst && retire_valid_o && retire_ready_i) compare_retire();
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: only %0d of %0d operations retired", retired, NUM_OPS);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    in_valid_i     = 1'b0;
    op_class_i     = OP_ALU;
    alu_op_i       = ALU_ADD;
    sys_op_i       = SYS_CSRRW;
    rd_i           = '0;
    rwen_i         = 1'b0;
    src1_i         = '0;
    src2_i         = '0;
    base_i         = '0;
    imm_i          = '0;
    pc_i           = '0;
    csr_addr_i     = '0;
    retire_ready_i = 1'b1;
    mstatus_m      = '0;
    mtvec_m        = '0;
    mepc_m         = '0;
    mcause_m       = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < NUM_OPS; n++) begin
      make_op(n);
      in_valid_i = 1'b1;
      while (in_ready_o !== 1'b1) @(negedge clk);
      @(negedge clk);                         // Accepted on the edge before
      in_valid_i = 1'b0;
      if (($random(seed) & 3) == 0) @(negedge clk);
    end
    while (expected_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
    if (retired != issued) begin
      $display("Retired %0d operations but issued %0d", retired, issued);
      other_errors++;
    end
    $display("Errors: data %0d, rd %0d, flag %0d, other %0d",
             data_errors, rd_errors, flag_errors, other_errors);
    if (data_errors + rd_errors + flag_errors + other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
exu_pkg.sv
exu_alu.sv
exu_csr_file.sv
exu_stage.sv
exu_data_mem.sv
exu_retire.sv
exu_top.sv
exu_props.sv
tb_exu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu_top -f src.f \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vtb_exu_top > sim.log 2>&1 ; cat sim.log
grep -qx "=== PASS ===" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
